// File: Bender.yml
package:
  name: uart_trx

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/uart_trx.sv
  - target: test
    files:
      - test/uart_trx_tb.sv

// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  ////////////////////////////////////////
  // Timing of the serial line.
  ////////////////////////////////////////

  // 50 MHz system clock divided down to 19200 baud.
  localparam int baud_div = 2604;          // Clock cycles per serial bit.
  localparam int half_baud_div = baud_div / 2; // Cycles from start edge to mid start bit.
  localparam int frame_bits = 10;          // Start bit, eight data bits and one stop bit.

  ////////////////////////////////////////
  // Vector types.
  ////////////////////////////////////////

  typedef logic [7:0] byte_t;       // One data word on the line.
  typedef logic [11:0] baud_cnt_t;  // Wide enough to hold baud_div.
  typedef logic [3:0] bit_cnt_t;    // Wide enough to count a whole frame.

  ////////////////////////////////////////
  // State machines.
  ////////////////////////////////////////

  // The transmitter is either waiting for a strobe or sending a frame.
  typedef enum logic {
    tx_idle,  // Line held high and waiting for trmt.
    tx_send   // Shifting out the ten bits of a frame.
  } tx_state_t;

  // The receiver walks through the parts of one frame.
  typedef enum logic [1:0] {
    rx_idle,   // Waiting for a falling edge on the line.
    rx_start,  // Waiting for the middle of the start bit.
    rx_data,   // Sampling the eight data bits.
    rx_stop    // Sampling the stop bit.
  } rx_state_t;

  // What the receiver hands to the host once a frame is complete.
  typedef struct packed {
    byte_t data;      // Received byte with bit 0 taken first off the line.
    logic  frame_err; // Set when the stop bit was sampled low.
  } rx_result_t;

endpackage

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                 clk,       // System clock.
  input  logic                 rst_n,     // Asynchronous active low reset.
  input  logic                 rx,        // Serial input from an unrelated clock domain.
  input  logic                 clr_rdy,   // Host strobe that acknowledges a received byte.
  output logic                 rx_rdy,    // A frame is complete and rx_result holds it.
  output uart_pkg::rx_result_t rx_result  // Received byte and its framing error flag.
);

  ////////////////////////////////////////
  // Internal signals.
  ////////////////////////////////////////

  logic                rx_meta;    // First synchronizer stage.
  logic                rx_sync;    // Second stage and the line level the FSM uses.
  logic                rx_prev;    // Line level one cycle earlier.
  logic                fall;       // Line has just gone from high to low.
  uart_pkg::rx_state_t state;      // Current state of the deframer.
  uart_pkg::rx_state_t nxt_state;  // State taken on the next clock.
  uart_pkg::baud_cnt_t baud_cnt;   // Cycles left until the next sample point.
  uart_pkg::bit_cnt_t  bit_cnt;    // Data bits sampled so far.
  uart_pkg::byte_t     shft_reg;   // Data bits collected with bit 0 arriving first.
  logic                tick;       // Counter has reached a sample point.
  logic                start;      // Falling edge seen while idle.
  logic                load_bit;   // Reload the counter for a full bit period.
  logic                take_bit;   // Sample a data bit into the shift register.
  logic                set_rdy;    // Stop bit sampled and the frame is done.

  ////////////////////////////////////////
  // Input synchronizer.
  ////////////////////////////////////////

  // Presetting to one keeps a reset from looking like a start bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;                           // May go metastable.
      rx_sync <= rx_meta;                      // Settled copy of the line.
      rx_prev <= rx_sync;                      // Kept for edge detection.
    end
  end

  assign fall = rx_prev && !rx_sync;           // High to low marks a possible start bit.
  assign tick = (baud_cnt == '0);              // Sample points sit where the count runs out.

  ////////////////////////////////////////
  // Datapath.
  ////////////////////////////////////////

  // Down counter. Half a bit reaches the middle of the start bit and full bits follow.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (start) begin
      baud_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::half_baud_div);
    end else if (load_bit) begin
      baud_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::baud_div); // Next sample baud_div + 1 later.
    end else if ((state != uart_pkg::rx_idle) && !tick) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // Counts data bits so the FSM knows when the byte is full.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (start) begin
      bit_cnt <= '0;                           // Every frame begins at data bit 0.
    end else if (take_bit) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Bits enter at the top and end up in order once all eight are in.
  always_ff @(posedge clk) begin
    if (take_bit) begin
      shft_reg <= {rx_sync, shft_reg[7:1]};
    end
  end

  // Result is captured at the stop sample and held until the next frame.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_result <= '0;
    end else if (set_rdy) begin
      rx_result.data <= shft_reg;
      rx_result.frame_err <= !rx_sync;         // A low stop bit is a framing error.
    end
  end

  // Ready flag. A new start edge or the host acknowledge clears it.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_rdy <= 1'b0;
    end else if (set_rdy) begin
      rx_rdy <= 1'b1;                          // Visible the cycle after the stop sample.
    end else if (clr_rdy || start) begin
      rx_rdy <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Control FSM.
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::rx_idle;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = state;                         // Hold by default.
    start = 1'b0;
    load_bit = 1'b0;
    take_bit = 1'b0;
    set_rdy = 1'b0;
    case (state)
      uart_pkg::rx_start: begin
        if (tick) begin
          if (rx_sync) begin
            nxt_state = uart_pkg::rx_idle;     // Line went back high, so it was a glitch.
          end else begin
            load_bit = 1'b1;                   // Real start bit. Time the first data bit.
            nxt_state = uart_pkg::rx_data;
          end
        end
      end
      uart_pkg::rx_data: begin
        if (tick) begin
          take_bit = 1'b1;
          load_bit = 1'b1;
          if (bit_cnt == uart_pkg::bit_cnt_t'($bits(uart_pkg::byte_t) - 1)) begin
            nxt_state = uart_pkg::rx_stop;     // Last data bit taken. The stop bit is next.
          end
        end
      end
      uart_pkg::rx_stop: begin
        if (tick) begin
          set_rdy = 1'b1;                      // Frame finished whatever the stop level.
          nxt_state = uart_pkg::rx_idle;
        end
      end
      default: begin
        if (fall) begin
          start = 1'b1;
          nxt_state = uart_pkg::rx_start;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/uart_trx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_trx (
  input  logic                 clk,       // System clock shared by both directions.
  input  logic                 rst_n,     // Asynchronous active low reset.
  input  logic                 trmt,      // One-cycle strobe that starts a transmit frame.
  input  uart_pkg::byte_t      tx_data,   // Byte to transmit.
  output logic                 tx_done,   // Transmit frame finished.
  output logic                 tx,        // Serial output.
  input  logic                 rx,        // Serial input.
  input  logic                 clr_rdy,   // Acknowledge for the received byte.
  output logic                 rx_rdy,    // Received byte is waiting.
  output uart_pkg::rx_result_t rx_result  // Received byte and framing error.
);

  ////////////////////////////////////////
  // Transmit direction.
  ////////////////////////////////////////

  // Framer that turns a byte into ten bits on tx.
  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (tx_data),
    .tx_done (tx_done),
    .tx      (tx)
  );

  ////////////////////////////////////////
  // Receive direction.
  ////////////////////////////////////////

  // Deframer that recovers a byte from rx. Both sides run fully independently.
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .clr_rdy   (clr_rdy),
    .rx_rdy    (rx_rdy),
    .rx_result (rx_result)
  );

  // The serial pins are kept apart so the line can be looped outside.

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic            clk,     // System clock.
  input  logic            rst_n,   // Asynchronous active low reset.
  input  logic            trmt,    // One-cycle strobe that asks for a frame to be sent.
  input  uart_pkg::byte_t tx_data, // Byte to send and valid together with trmt.
  output logic            tx_done, // High from the end of a frame until the next accepted trmt.
  output logic            tx       // Serial output which idles high.
);

  ////////////////////////////////////////
  // Internal signals.
  ////////////////////////////////////////

  uart_pkg::tx_state_t state;      // Current state of the framer.
  uart_pkg::tx_state_t nxt_state;  // State taken on the next clock.
  logic [8:0]          shft_reg;   // Data byte above the start bit.
  uart_pkg::baud_cnt_t baud_cnt;   // Cycles spent on the current bit.
  uart_pkg::bit_cnt_t  bit_cnt;    // Bits already shifted out of the frame.
  logic                init;       // Strobe accepted, so load the shift register.
  logic                shift;      // Current bit period is over.
  logic                sending;    // Frame still has bits left to send.
  logic                set_done;   // Last bit period has just finished.

  ////////////////////////////////////////
  // Datapath.
  ////////////////////////////////////////

  // The shift register holds the line level in bit 0 and refills with ones from the top.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      shft_reg <= '1;                          // All ones keeps the line idle.
    end else if (init) begin
      shft_reg <= {tx_data, 1'b0};             // Byte sits above the low start bit.
    end else if (shift) begin
      shft_reg <= {1'b1, shft_reg[8:1]};       // Next bit moves down and a stop one enters.
    end
  end

  // Each bit lasts from count 0 up to baud_div inclusive.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (init || shift) begin
      baud_cnt <= '0;                          // A fresh bit period begins.
    end else if (sending) begin
      baud_cnt <= baud_cnt + 1'b1;             // Count cycles of the bit on the line.
    end
  end

  // Counts the bits of the frame that have left the shift register.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (init) begin
      bit_cnt <= '0;                           // New frame starts at the start bit.
    end else if (shift) begin
      bit_cnt <= bit_cnt + 1'b1;               // One more bit is finished.
    end
  end

  assign shift = sending && (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::baud_div)); // End of bit.
  assign tx = shft_reg[0];                     // The line follows the bottom of the register.

  // Set and clear flop for the done flag. A new frame clears it first.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      tx_done <= 1'b0;
    end else if (init) begin
      tx_done <= 1'b0;                         // Cleared on the cycle after the accepted strobe.
    end else if (set_done) begin
      tx_done <= 1'b1;                         // Held until the host sends again.
    end
  end

  ////////////////////////////////////////
  // Control FSM.
  ////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::tx_idle;
    end else begin
      state <= nxt_state;
    end
  end

  // Next state and strobes. A trmt during a frame is simply not looked at.
  always_comb begin
    nxt_state = state;                         // Stay put unless told otherwise.
    init = 1'b0;
    sending = 1'b0;
    set_done = 1'b0;
    case (state)
      uart_pkg::tx_send: begin
        if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::frame_bits)) begin
          set_done = 1'b1;                     // Stop bit has had its full period.
          nxt_state = uart_pkg::tx_idle;
        end else begin
          sending = 1'b1;                      // Bits remain, so keep counting.
        end
      end
      default: begin
        if (trmt) begin
          init = 1'b1;                         // Accept the byte only while idle.
          nxt_state = uart_pkg::tx_send;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: test/uart_trx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_trx_tb;

  ////////////////////////////////////////
  // Run limits.
  ////////////////////////////////////////

  localparam int bit_cycles = uart_pkg::baud_div + 1;                 // Cycles per serial bit.
  localparam int frame_cycles = uart_pkg::frame_bits * bit_cycles;    // Cycles per frame.
  localparam int timeout_cycles = 23 * frame_cycles;  // Twenty frames plus setup and margin.

  logic                 clk;
  logic                 rst_n;
  logic                 trmt;
  uart_pkg::byte_t      tx_data;
  logic                 tx_done;
  logic                 tx;
  logic                 rx_line;      // Whatever currently feeds the receiver.
  logic                 clr_rdy;
  logic                 rx_rdy;
  uart_pkg::rx_result_t rx_result;
  logic                 line_sel;     // Zero loops tx back, one selects line_bit.
  logic                 line_bit;     // Serial level for frames built by the testbench.
  logic [15:0]          lfsr;         // Random state, stepped once per bit taken.
  uart_pkg::byte_t      sent_q[$];    // Scoreboard of bytes expected at the receiver.
  int                   cycles;
  int                   checks;
  int                   value_errs;
  int                   other_errs;
  logic                 done_seen;    // tx_done at the previous falling edge.
  logic                 trmt_seen;    // trmt at the previous falling edge.

  assign rx_line = line_sel ? line_bit : tx;

  uart_trx u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .trmt      (trmt),
    .tx_data   (tx_data),
    .tx_done   (tx_done),
    .tx        (tx),
    .rx        (rx_line),
    .clr_rdy   (clr_rdy),
    .rx_rdy    (rx_rdy),
    .rx_result (rx_result)
  );

  always #50 clk = ~clk;                        // 100 ns period.

  // Ends a run that has stopped making progress.
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Run stopped after %0d cycles without finishing the tests.", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // tx_done may only fall right after the DUT has seen a trmt.
  always @(negedge clk) begin
    if (rst_n && done_seen && !tx_done) begin
      checks = checks + 1;
      assert (trmt_seen) else begin
        other_errs = other_errs + 1;
        $display("tx_done dropped although no trmt was presented.");
      end
    end
    done_seen = tx_done;
    trmt_seen = trmt;
  end

  ////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13 and 11.
  endfunction

  // Eight steps give one byte.
  task automatic next_byte(output uart_pkg::byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks = checks + 1;
    assert (act === exp) else begin
      value_errs = value_errs + 1;
      $display("error %s expected %h got %h", name, exp, act);
    end
  endtask

  // Starts at the falling edge just after acceptance and samples each bit at its middle.
  task automatic check_frame(input uart_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};                    // Stop, data LSB first, start.
    repeat (uart_pkg::half_baud_div) @(posedge clk);
    for (int i = 0; i < uart_pkg::frame_bits; i++) begin
      @(negedge clk);
      check_eq($sformatf("tx bit %0d", i), frame[i], tx);
      if (i < uart_pkg::frame_bits - 1) begin
        repeat (uart_pkg::baud_div) @(posedge clk);
      end
    end
  endtask

  // Waits for rx_rdy, compares with the scoreboard and acknowledges.
  task automatic receive_check(input logic err_exp);
    uart_pkg::byte_t exp;
    int              n;
    exp = sent_q.pop_front();
    n = 0;
    while (!rx_rdy && n < frame_cycles + bit_cycles) begin
      @(negedge clk);
      n++;
    end
    checks = checks + 1;
    assert (rx_rdy) else begin
      other_errs = other_errs + 1;
      $display("rx_rdy never rose for byte %h.", exp);
    end
    check_eq("rx_result.data", exp, rx_result.data);
    check_eq("rx_result.frame_err", err_exp, rx_result.frame_err);
    @(posedge clk);
    clr_rdy <= 1'b1;                            // One-cycle acknowledge.
    @(posedge clk);
    clr_rdy <= 1'b0;
    @(negedge clk);
    check_eq("rx_rdy", 1'b0, rx_rdy);           // Cleared on the cycle after clr_rdy.
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!tx_done && n < 2 * bit_cycles) begin
      @(negedge clk);
      n++;
    end
    checks = checks + 1;
    assert (tx_done) else begin
      other_errs = other_errs + 1;
      $display("tx_done did not rise after the stop bit.");
    end
  endtask

  // Sends one byte in loopback. A poke issues a second trmt in the middle of the frame.
  task automatic send_frame(input uart_pkg::byte_t b, input logic done_exp, input logic poke,
                            input uart_pkg::byte_t poke_b);
    @(posedge clk);
    trmt <= 1'b1;
    tx_data <= b;
    sent_q.push_back(b);
    @(negedge clk);
    check_eq("tx_done", done_exp, tx_done);     // Still held until the strobe is taken.
    @(posedge clk);
    trmt <= 1'b0;
    @(negedge clk);
    check_eq("tx_done", 1'b0, tx_done);         // Low on the cycle after the strobe.
    fork
      check_frame(b);
      receive_check(1'b0);
      if (poke) begin
        repeat (4 * bit_cycles) @(posedge clk);
        trmt <= 1'b1;
        tx_data <= poke_b;
        @(posedge clk);
        trmt <= 1'b0;
      end
    join
    wait_done();
  endtask

  // Builds a frame on line_bit with a chosen stop level, each bit baud_div + 1 cycles.
  task automatic drive_frame(input uart_pkg::byte_t b, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, b, 1'b0};
    for (int i = 0; i < uart_pkg::frame_bits; i++) begin
      @(posedge clk);
      line_bit <= frame[i];
      repeat (uart_pkg::baud_div) @(posedge clk);
    end
    @(posedge clk);
    line_bit <= 1'b1;                           // Back to idle for one more bit.
    repeat (uart_pkg::baud_div) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////

  initial begin
    uart_pkg::byte_t b;
    logic            quiet;
    clk = 1'b0;
    rst_n = 1'b0;
    trmt = 1'b0;
    tx_data = '0;
    clr_rdy = 1'b0;
    line_sel = 1'b0;
    line_bit = 1'b1;
    lfsr = 16'd64145;
    cycles = 0;
    checks = 0;
    value_errs = 0;
    other_errs = 0;
    done_seen = 1'b0;
    trmt_seen = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("tx", 1'b1, tx);                   // State straight after reset.
    check_eq("tx_done", 1'b0, tx_done);
    check_eq("rx_rdy", 1'b0, rx_rdy);
    check_eq("rx_result", '0, rx_result);
    for (int i = 0; i < 16; i++) begin
      next_byte(b);
      send_frame(b, i != 0, 1'b0, '0);          // Only the first frame starts with tx_done low.
    end
    next_byte(b);
    send_frame(b, 1'b1, 1'b1, ~b);              // The poked byte must never appear.
    quiet = 1'b1;
    repeat (frame_cycles) begin
      @(negedge clk);
      if (tx !== 1'b1 || rx_rdy !== 1'b0) quiet = 1'b0;
    end
    checks = checks + 1;
    assert (quiet) else begin
      other_errs = other_errs + 1;
      $display("An extra frame followed the trmt issued while busy.");
    end
    @(posedge clk);
    line_sel <= 1'b1;                           // The testbench now owns the receive line.
    next_byte(b);
    sent_q.push_back(b);
    fork
      drive_frame(b, 1'b0);                     // Low stop bit.
      receive_check(1'b1);
    join
    next_byte(b);
    sent_q.push_back(b);
    fork
      drive_frame(b, 1'b1);
      receive_check(1'b0);
    join
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_trx.f
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_trx.sv
test/uart_trx_tb.sv
